// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

  // Data, address and instruction word
  typedef logic [15:0] wordT;
  typedef logic [2:0]  regIdxT;
  typedef logic [3:0]  opcodeT;
  typedef logic [2:0]  aluFuncT;
  typedef logic [2:0]  condT;
  typedef logic [3:0]  trapNrT;

  // Opcodes, bits 15..12 of the instruction
  localparam opcodeT opAlu     = 4'd0;
  localparam opcodeT opLdi     = 4'd1;
  localparam opcodeT opLd      = 4'd2;
  localparam opcodeT opSt      = 4'd3;
  localparam opcodeT opSkip    = 4'd4;
  localparam opcodeT opSyscall = 4'd5;
  localparam opcodeT opReti    = 4'd6;
  localparam opcodeT opHlt     = 4'd7;

  // ALU functions, bits 2..0
  localparam aluFuncT funcAdd   = 3'd0;
  localparam aluFuncT funcSub   = 3'd1;
  localparam aluFuncT funcAnd   = 3'd2;
  localparam aluFuncT funcOr    = 3'd3;
  localparam aluFuncT funcXor   = 3'd4;
  localparam aluFuncT funcShl1  = 3'd5;
  localparam aluFuncT funcShr1  = 3'd6;
  localparam aluFuncT funcPassA = 3'd7;

  // Skip conditions, tested on rA - rB
  localparam condT condZero     = 3'd0;
  localparam condT condNonZero  = 3'd1;
  localparam condT condNeg      = 3'd2;
  localparam condT condNonNeg   = 3'd3;
  localparam condT condPos      = 3'd4;
  localparam condT condNonPos   = 3'd5;
  localparam condT condAlways   = 3'd6;
  localparam condT condNever    = 3'd7;

  // Trap numbers, written to supervisor R1
  localparam trapNrT trapNone      = 4'd0;
  localparam trapNrT trapSyscall   = 4'd1;
  localparam trapNrT trapUart      = 4'd2;
  localparam trapNrT trapPageFault = 4'd3;

  typedef enum logic [2:0] {
    Fetch,
    Decode,
    Exec,
    Trap,
    Halt
  } cpuStateT;

endpackage

`default_nettype wire

// ==== common/ctrlIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface ctrlIf;

  cpuPkg::regIdxT  rA;
  cpuPkg::regIdxT  rB;
  cpuPkg::regIdxT  rd;
  cpuPkg::aluFuncT aluFunc;
  cpuPkg::condT    cond;
  cpuPkg::wordT    imm;
  logic            opSelImm;
  logic            resultFromMem;
  logic            regWrite;
  logic            pcAdvance;
  logic            skipCheck;
  logic            bankToSuper;
  logic            bankToUser;
  logic            trapWrite;

  modport decode (
    output rA, rB, rd, aluFunc, cond, imm, opSelImm, resultFromMem,
           regWrite, pcAdvance, skipCheck, bankToSuper, bankToUser, trapWrite
  );

  modport exec (input aluFunc, cond, imm, opSelImm, resultFromMem, skipCheck);

  modport regs (
    input rA, rB, rd, regWrite, pcAdvance, bankToSuper, bankToUser, trapWrite
  );

endinterface

`default_nettype wire

// ==== decode/controlDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module controlDecoder (
  input  logic         clk,
  input  logic         reset,
  input  cpuPkg::wordT ramOut,
  input  logic         pending,
  input  logic         inSuper,
  ctrlIf.decode        ctrl,
  output logic         ack,
  output logic         syscallReq,
  output logic         we,
  output logic         re,
  output logic         hlt,
  output logic         addrFromReg
);

  cpuPkg::cpuStateT state;
  cpuPkg::cpuStateT nextState;
  cpuPkg::wordT     ir;
  cpuPkg::opcodeT   opcode;
  logic             inExec;
  logic             inTrap;
  logic             writesReg;

  assign opcode = ir[15:12];
  assign inExec = (state == cpuPkg::Exec);
  assign inTrap = (state == cpuPkg::Trap);

  // IR loads straight from the memory output while fetching
  always_ff @(posedge clk) begin
    if (state == cpuPkg::Fetch) begin
      ir <= ramOut;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= cpuPkg::Fetch;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    case (state)
      cpuPkg::Fetch:  nextState = cpuPkg::Decode;
      cpuPkg::Decode: nextState = cpuPkg::Exec;
      cpuPkg::Exec: begin
        // Traps are taken at the fetch boundary and only from user code
        if (opcode == cpuPkg::opHlt) begin
          nextState = cpuPkg::Halt;
        end else if (pending && !inSuper) begin
          nextState = cpuPkg::Trap;
        end else begin
          nextState = cpuPkg::Fetch;
        end
      end
      cpuPkg::Trap:   nextState = cpuPkg::Fetch;
      cpuPkg::Halt:   nextState = cpuPkg::Halt;
      default:        nextState = cpuPkg::Fetch;
    endcase
  end

  // Field decode
  always_comb begin
    ctrl.rA            = ir[8:6];
    ctrl.rB            = ir[5:3];
    ctrl.rd            = ir[11:9];
    ctrl.cond          = ir[11:9];
    ctrl.imm           = {{7{ir[8]}}, ir[8:0]};
    ctrl.aluFunc       = cpuPkg::funcAdd;
    ctrl.opSelImm      = 1'b0;
    ctrl.resultFromMem = 1'b0;
    writesReg          = 1'b0;
    case (opcode)
      cpuPkg::opAlu: begin
        ctrl.aluFunc = ir[2:0];
        writesReg    = 1'b1;
      end
      cpuPkg::opLdi: begin
        // R0 plus immediate since the rA bits belong to the immediate
        ctrl.rA       = '0;
        ctrl.opSelImm = 1'b1;
        writesReg     = 1'b1;
      end
      cpuPkg::opLd: begin
        ctrl.resultFromMem = 1'b1;
        writesReg          = 1'b1;
      end
      cpuPkg::opSkip: begin
        ctrl.aluFunc = cpuPkg::funcSub;
      end
      default: begin
        writesReg = 1'b0;
      end
    endcase
  end

  // All strobes last a single cycle
  assign ctrl.regWrite    = inExec && writesReg;
  assign ctrl.pcAdvance   = inExec && (opcode != cpuPkg::opHlt);
  assign ctrl.skipCheck   = inExec && (opcode == cpuPkg::opSkip);
  assign ctrl.bankToUser  = inExec && (opcode == cpuPkg::opReti);
  assign ctrl.bankToSuper = inTrap;
  assign ctrl.trapWrite   = inTrap;
  assign ack              = inTrap;
  assign syscallReq       = inExec && (opcode == cpuPkg::opSyscall) && !inSuper;

  // Memory side, no read while reset is held
  assign re          = (state == cpuPkg::Fetch) && !reset;
  assign we          = inExec && (opcode == cpuPkg::opSt);
  assign addrFromReg = inExec && ((opcode == cpuPkg::opLd) || (opcode == cpuPkg::opSt));
  assign hlt         = (state == cpuPkg::Halt);

endmodule

`default_nettype wire

// ==== decode/trapEncoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module trapEncoder (
  input  logic           clk,
  input  logic           reset,
  input  logic           uartIntr,
  input  logic           pageFault,
  input  logic           syscallReq,
  input  logic           ack,
  output logic           pending,
  output cpuPkg::trapNrT trapNr
);

  logic faultLatch;
  logic syscallLatch;
  logic faultAny;
  logic syscallAny;

  // Live request counts too, so a syscall traps on the very next boundary
  assign faultAny   = faultLatch || pageFault;
  assign syscallAny = syscallLatch || syscallReq;

  always_ff @(posedge clk) begin
    if (reset) begin
      faultLatch   <= 1'b0;
      syscallLatch <= 1'b0;
    end else begin
      if (pageFault) begin
        faultLatch <= 1'b1;
      end
      if (syscallReq) begin
        syscallLatch <= 1'b1;
      end
      // Granted source is consumed by ack
      if (ack && (trapNr == cpuPkg::trapPageFault)) begin
        faultLatch <= 1'b0;
      end
      if (ack && (trapNr == cpuPkg::trapSyscall)) begin
        syscallLatch <= 1'b0;
      end
    end
  end

  // Page fault first, then UART level, then syscall
  always_comb begin
    if (faultAny) begin
      trapNr = cpuPkg::trapPageFault;
    end else if (uartIntr) begin
      trapNr = cpuPkg::trapUart;
    end else if (syscallAny) begin
      trapNr = cpuPkg::trapSyscall;
    end else begin
      trapNr = cpuPkg::trapNone;
    end
  end

  assign pending = faultAny || uartIntr || syscallAny;

endmodule

`default_nettype wire

// ==== execute/aluSkip.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluSkip (
  ctrlIf.exec          ctrl,
  input  cpuPkg::wordT opA,
  input  cpuPkg::wordT opB,
  input  cpuPkg::wordT ramOut,
  output cpuPkg::wordT result,
  output logic         skip
);

  cpuPkg::wordT opSecond;
  cpuPkg::wordT aluOut;
  logic         isZero;
  logic         isNeg;
  logic         condMet;

  assign opSecond = ctrl.opSelImm ? ctrl.imm : opB;

  always_comb begin
    case (ctrl.aluFunc)
      cpuPkg::funcAdd:   aluOut = opA + opSecond;
      cpuPkg::funcSub:   aluOut = opA - opSecond;
      cpuPkg::funcAnd:   aluOut = opA & opSecond;
      cpuPkg::funcOr:    aluOut = opA | opSecond;
      cpuPkg::funcXor:   aluOut = opA ^ opSecond;
      cpuPkg::funcShl1:  aluOut = {opA[14:0], 1'b0};
      cpuPkg::funcShr1:  aluOut = {1'b0, opA[15:1]};
      default:           aluOut = opA;
    endcase
  end

  // Loads take the memory word, everything else the ALU
  assign result = ctrl.resultFromMem ? ramOut : aluOut;

  // Flags of rA - rB
  assign isZero = (aluOut == '0);
  assign isNeg  = aluOut[15];

  always_comb begin
    case (ctrl.cond)
      cpuPkg::condZero:    condMet = isZero;
      cpuPkg::condNonZero: condMet = !isZero;
      cpuPkg::condNeg:     condMet = isNeg;
      cpuPkg::condNonNeg:  condMet = !isNeg;
      cpuPkg::condPos:     condMet = !isNeg && !isZero;
      cpuPkg::condNonPos:  condMet = isNeg || isZero;
      cpuPkg::condAlways:  condMet = 1'b1;
      default:             condMet = 1'b0;
    endcase
  end

  assign skip = ctrl.skipCheck && condMet;

endmodule

`default_nettype wire

// ==== logic/cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu #(
  parameter cpuPkg::wordT trapVector  = 16'h0100,
  parameter cpuPkg::wordT userStartPc = 16'h0000
) (
  input  logic         clk,
  input  logic         reset,
  input  cpuPkg::wordT ramOut,
  input  logic         uartIntr,
  input  logic         pageFault,
  output cpuPkg::wordT ramIn,
  output cpuPkg::wordT ramAddr,
  output logic         we,
  output logic         re,
  output logic         hlt
);

  cpuPkg::wordT   opA;
  cpuPkg::wordT   opB;
  cpuPkg::wordT   pc;
  cpuPkg::wordT   aluResult;
  cpuPkg::trapNrT trapNr;
  logic           skip;
  logic           pending;
  logic           ack;
  logic           syscallReq;
  logic           inSuper;
  logic           addrFromReg;

  ctrlIf ctrl ();

  controlDecoder controlDecoder (
    .clk         (clk),
    .reset       (reset),
    .ramOut      (ramOut),
    .pending     (pending),
    .inSuper     (inSuper),
    .ctrl        (ctrl.decode),
    .ack         (ack),
    .syscallReq  (syscallReq),
    .we          (we),
    .re          (re),
    .hlt         (hlt),
    .addrFromReg (addrFromReg)
  );

  trapEncoder trapEncoder (
    .clk        (clk),
    .reset      (reset),
    .uartIntr   (uartIntr),
    .pageFault  (pageFault),
    .syscallReq (syscallReq),
    .ack        (ack),
    .pending    (pending),
    .trapNr     (trapNr)
  );

  aluSkip aluSkip (
    .ctrl   (ctrl.exec),
    .opA    (opA),
    .opB    (opB),
    .ramOut (ramOut),
    .result (aluResult),
    .skip   (skip)
  );

  registerBank #(
    .trapVector  (trapVector),
    .userStartPc (userStartPc)
  ) registerBank (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl.regs),
    .result  (aluResult),
    .skip    (skip),
    .trapNr  (trapNr),
    .opA     (opA),
    .opB     (opB),
    .pc      (pc),
    .inSuper (inSuper)
  );

  // Fetch uses the PC, loads and stores address through rA
  assign ramAddr = addrFromReg ? opA : pc;
  assign ramIn   = opB;

endmodule

`default_nettype wire

// ==== logic/registerBank.sv ====
`timescale 1ns/1ps
`default_nettype none

module registerBank #(
  parameter cpuPkg::wordT trapVector  = 16'h0100,
  parameter cpuPkg::wordT userStartPc = 16'h0000
) (
  input  logic           clk,
  input  logic           reset,
  ctrlIf.regs            ctrl,
  input  cpuPkg::wordT   result,
  input  logic           skip,
  input  cpuPkg::trapNrT trapNr,
  output cpuPkg::wordT   opA,
  output cpuPkg::wordT   opB,
  output cpuPkg::wordT   pc,
  output logic           inSuper
);

  localparam logic userBank  = 1'b0;
  localparam logic superBank = 1'b1;

  // Bank 0 is user, bank 1 is supervisor; R0 has no storage
  cpuPkg::wordT regFile [0:1][1:7];
  cpuPkg::wordT pcStep;

  always_comb begin
    if (ctrl.rA == '0) begin
      opA = '0;
    end else begin
      opA = regFile[inSuper][ctrl.rA];
    end
  end

  always_comb begin
    if (ctrl.rB == '0) begin
      opB = '0;
    end else begin
      opB = regFile[inSuper][ctrl.rB];
    end
  end

  assign pc     = regFile[inSuper][7];
  assign pcStep = skip ? 16'd4 : 16'd2;

  always_ff @(posedge clk) begin
    if (reset) begin
      regFile[userBank][7]  <= userStartPc;
      regFile[superBank][7] <= trapVector;
      inSuper               <= userBank;
    end else begin
      if (ctrl.pcAdvance) begin
        regFile[inSuper][7] <= pc + pcStep;
      end

      // A write to R7 wins over the advance
      if (ctrl.regWrite && (ctrl.rd != '0)) begin
        regFile[inSuper][ctrl.rd] <= result;
      end

      if (ctrl.trapWrite) begin
        regFile[superBank][1] <= {12'b0, trapNr};
      end

      if (ctrl.bankToSuper) begin
        inSuper <= superBank;
      end

      // Return from trap, handler restarts at the vector next time
      if (ctrl.bankToUser) begin
        inSuper               <= userBank;
        regFile[superBank][7] <= trapVector;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbCpu -o simCpu
./obj_dir/simCpu | tee sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "Simulation reported a failure"
  exit 1
fi
echo "Simulation finished without failure"

// ==== sources.f ====
common/cpuPkg.sv
common/ctrlIf.sv
decode/trapEncoder.sv
decode/controlDecoder.sv
execute/aluSkip.sv
logic/registerBank.sv
logic/cpu.sv
testbench/ramModel.sv
testbench/tbCpu.sv

// ==== testbench/ramModel.sv ====
`timescale 1ns/1ps
`default_nettype none

module ramModel (
  input  logic        clk,
  input  logic [15:0] addr,
  input  logic [15:0] dataIn,
  input  logic        we,
  output logic [15:0] dataOut
);

  // 256 words, byte address bits 8..1 select the word
  logic [15:0] words [0:255];

  // Every store in order, with the full byte address
  logic [15:0] logAddr [0:255];
  logic [15:0] logData [0:255];
  int          logCount = 0;

  assign dataOut = words[addr[8:1]];

  always @(posedge clk) begin
    if (we) begin
      words[addr[8:1]] <= dataIn;
      if (logCount < 256) begin
        logAddr[logCount] <= addr;
        logData[logCount] <= dataIn;
        logCount          <= logCount + 1;
      end
    end
  end

endmodule

`default_nettype wire

// ==== testbench/tbCpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module tbCpu;

  localparam logic [15:0] trapVector = 16'h0100;
  localparam logic [15:0] outAddr    = 16'hFFFE;
  localparam logic [15:0] trapAddr   = 16'hFFFC;
  localparam logic [15:0] dataAddr   = 16'hFFF0;
  localparam int          waitLimit  = 200;

  logic        clk       = 1'b0;
  logic        reset     = 1'b1;
  logic        uartIntr  = 1'b0;
  logic        pageFault = 1'b0;
  logic [15:0] ramOut;
  logic [15:0] ramIn;
  logic [15:0] ramAddr;
  logic        we;
  logic        re;
  logic        hlt;
  logic        weLast = 1'b0;

  logic [15:0] lfsrState  = 16'd79;
  int          errorCount = 0;
  int          testErrors = 0;
  int          testsFailed = 0;
  int          nextLog    = 0;
  int          progAddr   = 0;
  int          sinceFetch = 0;
  bit          seenFetch  = 1'b0;
  bit          timedOut   = 1'b0;
  logic [15:0] valA;
  logic [15:0] valB;
  logic [15:0] pVal;
  logic [15:0] memVal;
  logic [15:0] r3Model;

  cpu #(
    .trapVector  (trapVector),
    .userStartPc (16'h0000)
  ) uut (
    .clk       (clk),
    .reset     (reset),
    .ramOut    (ramOut),
    .uartIntr  (uartIntr),
    .pageFault (pageFault),
    .ramIn     (ramIn),
    .ramAddr   (ramAddr),
    .we        (we),
    .re        (re),
    .hlt       (hlt)
  );

  ramModel ram (
    .clk     (clk),
    .addr    (ramAddr),
    .dataIn  (ramIn),
    .we      (we),
    .dataOut (ramOut)
  );

  always #2 clk = ~clk;

  always @(posedge clk) weLast <= we;

  task automatic countError();
    errorCount++;
    testErrors++;
  endtask

  task automatic protocolError(input string what);
    $display("ERROR at %0t ns: %s", $time, what);
    countError();
  endtask

  // A store is a single cycle of we
  assert property (@(posedge clk) disable iff (reset) !(we && weLast))
    else protocolError("write enable stayed high for two cycles");

  // Halted core keeps the bus quiet
  assert property (@(posedge clk) disable iff (reset) hlt |-> (!re && !we))
    else protocolError("memory strobe seen while halted");

  // One extra cycle between fetches only when a trap redirects to the vector
  always @(negedge clk) begin
    if (reset) begin
      assert (!re) else begin
        $display("ERROR at %0t ns: read strobe high while reset is held", $time);
        countError();
      end
      sinceFetch = 0;
      seenFetch  = 1'b0;
    end else if (re) begin
      if (seenFetch) begin
        assert (sinceFetch == 3 || (sinceFetch == 4 && ramAddr == trapVector)) else begin
          $display("ERROR at %0t ns: fetch came %0d cycles after the previous one",
                   $time, sinceFetch);
          countError();
        end
      end
      sinceFetch = 1;
      seenFetch  = 1'b1;
    end else begin
      sinceFetch++;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [15:0] takeBits(input int count);
    logic        lsb;
    logic [15:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      lsb       = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (lsb) begin
        lfsrState = lfsrState ^ 16'hB400;
      end
      value = {value[14:0], lsb};
    end
    return value;
  endfunction

  function automatic logic [15:0] signExt9(input logic [8:0] v);
    return {{7{v[8]}}, v};
  endfunction

  function automatic logic [15:0] instrWord(input logic [3:0] op, input logic [2:0] f1,
                                            input logic [2:0] f2, input logic [2:0] f3,
                                            input logic [2:0] f4);
    return {op, f1, f2, f3, f4};
  endfunction

  function automatic logic [15:0] ldiWord(input logic [2:0] rd, input logic [8:0] imm);
    return {4'd1, rd, imm};
  endfunction

  function automatic logic [15:0] storeWord(input logic [2:0] addrReg, input logic [2:0] dataReg);
    return instrWord(4'd3, 3'd0, addrReg, dataReg, 3'd0);
  endfunction

  function automatic logic [15:0] aluRule(input logic [2:0] func, input logic [15:0] a,
                                          input logic [15:0] b);
    case (func)
      3'd0:    return a + b;
      3'd1:    return a - b;
      3'd2:    return a & b;
      3'd3:    return a | b;
      3'd4:    return a ^ b;
      3'd5:    return a << 1;
      3'd6:    return a >> 1;
      default: return a;
    endcase
  endfunction

  function automatic logic condHolds(input logic [2:0] c, input logic [15:0] d);
    case (c)
      3'd0:    return d == 16'd0;
      3'd1:    return d != 16'd0;
      3'd2:    return d[15];
      3'd3:    return !d[15];
      3'd4:    return !d[15] && d != 16'd0;
      3'd5:    return d[15] || d == 16'd0;
      3'd6:    return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  // Register pairs for zero, negative and positive differences
  function automatic logic [5:0] skipRegs(input int pair);
    case (pair)
      0:       return {3'd4, 3'd4};
      1:       return {3'd0, 3'd4};
      default: return {3'd4, 3'd0};
    endcase
  endfunction

  task automatic placeWord(input logic [15:0] w);
    ram.words[progAddr] = w;
    progAddr++;
  endtask

  task automatic assembleProgram();
    logic [15:0] bits;
    logic [5:0]  regs;
    int          id;
    for (int i = 0; i < 256; i++) begin
      ram.words[i] = {8'hF0, 8'(i)};
    end
    bits   = takeBits(9);
    valA   = signExt9(bits[8:0]);
    bits   = takeBits(9);
    valB   = signExt9(bits[8:0]);
    bits   = takeBits(8);
    pVal   = {8'h00, bits[7:0] | 8'h01};
    bits   = takeBits(9);
    memVal = signExt9(bits[8:0]);
    // R6 points at the output word and R1 and R2 hold the operands
    placeWord(ldiWord(3'd6, 9'h1FE));
    placeWord(ldiWord(3'd1, valA[8:0]));
    placeWord(ldiWord(3'd2, valB[8:0]));
    for (int f = 0; f < 8; f++) begin
      placeWord(instrWord(4'd0, 3'd3, 3'd1, 3'd2, 3'(f)));
      placeWord(storeWord(3'd6, 3'd3));
    end
    placeWord(ldiWord(3'd4, pVal[8:0]));
    id = 0;
    for (int c = 0; c < 8; c++) begin
      for (int pair = 0; pair < 3; pair++) begin
        id++;
        regs = skipRegs(pair);
        placeWord(instrWord(4'd4, 3'(c), regs[5:3], regs[2:0], 3'd0));
        placeWord(ldiWord(3'd3, 9'(id)));
        placeWord(storeWord(3'd6, 3'd3));
      end
    end
    placeWord(ldiWord(3'd1, 9'h1F0));
    placeWord(ldiWord(3'd2, memVal[8:0]));
    placeWord(storeWord(3'd1, 3'd2));
    placeWord(instrWord(4'd2, 3'd3, 3'd1, 3'd0, 3'd0));
    placeWord(storeWord(3'd6, 3'd3));
    placeWord(16'h5000);
    placeWord(storeWord(3'd6, 3'd4));
    // Room for the external traps to land
    repeat (12) placeWord(16'hF000);
    placeWord(16'h7000);
    // Handler stores supervisor R1 and returns
    progAddr = int'(trapVector >> 1);
    placeWord(ldiWord(3'd6, 9'h1FC));
    placeWord(storeWord(3'd6, 3'd1));
    placeWord(16'h6000);
  endtask

  task automatic expectStore(input logic [15:0] addr, input logic [15:0] data, input string what);
    int waited;
    waited = 0;
    if (timedOut) begin
      return;
    end
    while (ram.logCount <= nextLog && waited < waitLimit) begin
      @(negedge clk);
      waited++;
    end
    if (ram.logCount <= nextLog) begin
      $display("TIMEOUT at %0t ns: no store for %s within %0d cycles", $time, what, waitLimit);
      timedOut = 1'b1;
      countError();
      return;
    end
    assert (ram.logAddr[nextLog] == addr && ram.logData[nextLog] == data) else begin
      $display("MISMATCH at %0t ns: %s stored %h at %h, expected %h at %h", $time, what,
               ram.logData[nextLog], ram.logAddr[nextLog], data, addr);
      countError();
    end
    nextLog++;
  endtask

  task automatic closeTest(input int num, input string name);
    if (testErrors == 0) begin
      $display("Test %0d %s: passed", num, name);
    end else begin
      $display("Test %0d %s: failed with %0d errors", num, name, testErrors);
      testsFailed++;
    end
    testErrors = 0;
  endtask

  task automatic aluFunctionsTest();
    for (int f = 0; f < 8; f++) begin
      r3Model = aluRule(3'(f), valA, valB);
      expectStore(outAddr, r3Model, "ALU result");
    end
    closeTest(1, "ALU functions");
  endtask

  task automatic skipConditionsTest();
    logic [15:0] diff;
    int          id;
    id = 0;
    for (int c = 0; c < 8; c++) begin
      for (int pair = 0; pair < 3; pair++) begin
        id++;
        case (pair)
          0:       diff = 16'h0000;
          1:       diff = 16'h0000 - pVal;
          default: diff = pVal;
        endcase
        // Marker LDI only runs when no skip happens
        if (!condHolds(3'(c), diff)) begin
          r3Model = 16'(id);
        end
        expectStore(outAddr, r3Model, "skip marker");
      end
    end
    closeTest(2, "skip conditions");
  endtask

  task automatic loadStoreTest();
    expectStore(dataAddr, memVal, "data word");
    expectStore(outAddr, memVal, "loaded copy");
    closeTest(3, "load and store");
  endtask

  task automatic syscallReturnTest();
    expectStore(trapAddr, 16'd1, "syscall handler");
    expectStore(outAddr, pVal, "store after return");
    closeTest(4, "syscall and return");
  endtask

  task automatic externalTrapsTest();
    uartIntr = 1'b1;
    expectStore(trapAddr, 16'd2, "UART handler");
    uartIntr  = 1'b0;
    pageFault = 1'b1;
    @(negedge clk);
    pageFault = 1'b0;
    expectStore(trapAddr, 16'd3, "page fault handler");
    // The fault goes first when both arrive together
    uartIntr  = 1'b1;
    pageFault = 1'b1;
    @(negedge clk);
    pageFault = 1'b0;
    expectStore(trapAddr, 16'd3, "page fault before UART");
    expectStore(trapAddr, 16'd2, "UART after page fault");
    uartIntr = 1'b0;
    closeTest(5, "external traps");
  endtask

  task automatic haltTimingTest();
    int waited;
    waited = 0;
    while (!hlt && waited < waitLimit && !timedOut) begin
      @(negedge clk);
      waited++;
    end
    if (hlt !== 1'b1) begin
      $display("TIMEOUT at %0t ns: core did not halt", $time);
      timedOut = 1'b1;
      countError();
    end else begin
      repeat (16) begin
        @(negedge clk);
        assert (hlt && !re && !we) else begin
          $display("ERROR at %0t ns: core left the halted state", $time);
          countError();
        end
      end
      assert (ram.logCount == nextLog) else begin
        $display("ERROR at %0t ns: %0d unexpected stores", $time, ram.logCount - nextLog);
        countError();
      end
    end
    closeTest(6, "halt and timing");
  endtask

  initial begin
    assembleProgram();
    repeat (3) @(negedge clk);
    reset = 1'b0;
    aluFunctionsTest();
    skipConditionsTest();
    loadStoreTest();
    syscallReturnTest();
    externalTrapsTest();
    haltTimingTest();
    $display("Tests run: 6, failed: %0d, errors: %0d", testsFailed, errorCount);
    if (errorCount == 0 && !timedOut) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire
